/* design/isa_pkg.sv */
package isa_pkg;

  localparam int xlen     = 32;
  localparam int nregs    = 32;
  localparam int inst_len = 4;   // Fall-through PC step

  typedef logic [xlen-1:0]          word_t;
  typedef logic [$clog2(nregs)-1:0] reg_idx_t;

  typedef enum logic [4:0] {
    op_lui,
    op_auipc,
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_addi,
    op_slti,
    op_sltiu,
    op_xori,
    op_ori,
    op_andi,
    op_slli,
    op_srli,
    op_srai,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu
  } op_e;

  // Conditional branches never write rd
  function automatic logic is_branch(op_e op);
    return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
  endfunction

  function automatic logic is_jump(op_e op);
    return op inside {op_jal, op_jalr};
  endfunction

endpackage

/* design/exu_pkg.sv */
package exu_pkg;

  typedef struct packed {
    isa_pkg::op_e     op;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t   imm;
    isa_pkg::word_t   pc;
    isa_pkg::word_t   pred_pc_next;  // Front end's guess
  } issue_t;

  typedef struct packed {
    logic             valid;
    isa_pkg::op_e     op;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t   pc;
    isa_pkg::word_t   pred_pc_next;
    isa_pkg::word_t   imm;
    isa_pkg::word_t   rs1_data;
    isa_pkg::word_t   rs2_data;
  } exec_t;

  typedef struct packed {
    logic             valid;
    isa_pkg::word_t   pc;
    isa_pkg::word_t   pc_next;
    logic             rd_wr;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t   rd_data;
    logic             br;        // Branch or jump
    logic             br_taken;
    logic             br_miss;   // pc_next differs from prediction
  } retire_t;

  typedef struct packed {
    logic           valid;
    isa_pkg::word_t pc;
  } redirect_t;

endpackage

/* design/exu_dispatch.sv */
`timescale 1ns/10ps

module exu_dispatch (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  output logic               ack,
  input  exu_pkg::issue_t    issue,
  input  exu_pkg::redirect_t redirect,
  input  logic               release_vld,
  input  isa_pkg::reg_idx_t  release_rd,
  output isa_pkg::reg_idx_t  rs1,
  output isa_pkg::reg_idx_t  rs2,
  input  isa_pkg::word_t     rs1_data,
  input  isa_pkg::word_t     rs2_data,
  output exu_pkg::exec_t     exec
);

import isa_pkg::*;

typedef enum logic [1:0] {idle, accept, release_wait} state_e;

state_e           state;
logic [nregs-1:0] busy;
logic [nregs-1:0] rel_mask;
logic [nregs-1:0] busy_eff;
logic             srcs_ready;
logic             wrong_path;
word_t            fix_pc;
word_t            target_pc;
logic             discard;
logic             take;
logic             keep;
logic             wr_rd;

assign rs1 = issue.rs1;
assign rs2 = issue.rs2;

always_comb
  begin
  // A younger writer of the same rd in execute keeps the bit busy
  rel_mask = '0;
  rel_mask[release_rd] = release_vld &&
    !(exec.valid && !is_branch(exec.op) && (exec.rd == release_rd));
  busy_eff = busy & ~rel_mask;
  srcs_ready = !busy_eff[issue.rs1] && !busy_eff[issue.rs2];
  target_pc = redirect.valid ? redirect.pc : fix_pc;
  discard = (redirect.valid || wrong_path) && (issue.pc != target_pc);
  take = (state == idle) && req && srcs_ready;
  keep = take && !discard;
  wr_rd = (issue.rd != '0) && !is_branch(issue.op);
  end

always_ff @(posedge clk)
  begin
  case (state)
    idle:
      if (take)
        begin
        ack <= 1'b1;
        state <= accept;
        end
    accept:
      begin
      state <= release_wait;
      if (!req)
        begin
        ack <= 1'b0;
        state <= idle;
        end
      end
    release_wait:
      if (!req)
        begin
        ack <= 1'b0;
        state <= idle;
        end
    default:
      state <= idle;
  endcase

  busy <= busy_eff;
  if (keep && wr_rd)
    busy[issue.rd] <= 1'b1;

  if (redirect.valid)
    wrong_path <= 1'b1;
  if (keep)
    wrong_path <= 1'b0;           // Back on the corrected path

  if (rst)
    begin
    state <= idle;
    ack <= 1'b0;
    busy <= '0;
    wrong_path <= 1'b0;
    end
  end

always_ff @(posedge clk)
  begin
  exec.valid <= keep;             // Discarded ones are acked only
  if (redirect.valid)
    fix_pc <= redirect.pc;
  if (take)
    begin
    exec.op <= issue.op;
    exec.rd <= issue.rd;
    exec.pc <= issue.pc;
    exec.pred_pc_next <= issue.pred_pc_next;
    exec.imm <= issue.imm;
    exec.rs1_data <= rs1_data;
    exec.rs2_data <= rs2_data;
    end
  if (rst)
    exec.valid <= 1'b0;
  end

endmodule

/* design/exu_execute.sv */
`timescale 1ns/10ps

module exu_execute (
  input  logic               clk,
  input  logic               rst,
  input  exu_pkg::exec_t     exec,
  output exu_pkg::retire_t   wb,
  output exu_pkg::redirect_t redirect
);

import isa_pkg::*;
import exu_pkg::*;

word_t   op_a;
word_t   op_b;
word_t   seq_pc;
word_t   target;
logic    taken;
logic    miss;
retire_t res;

assign op_a = exec.rs1_data;

// Second operand: immediate forms take imm, the rest rs2
always_comb
  begin
  case (exec.op)
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai:
      op_b = exec.imm;
    default:
      op_b = exec.rs2_data;
  endcase
  end

always_comb
  begin
  seq_pc = exec.pc + word_t'(inst_len);
  target = exec.pc + exec.imm;    // jal and branches
  taken = 1'b0;
  res.rd_data = '0;

  case (exec.op)
    op_lui:
      res.rd_data = exec.imm;
    op_auipc:
      res.rd_data = exec.pc + exec.imm;
    op_add, op_addi:
      res.rd_data = op_a + op_b;
    op_sub:
      res.rd_data = op_a - op_b;
    op_sll, op_slli:
      res.rd_data = op_a << op_b[4:0];    // Low 5 bits only
    op_slt, op_slti:
      res.rd_data = word_t'($signed(op_a) < $signed(op_b));
    op_sltu, op_sltiu:
      res.rd_data = word_t'(op_a < op_b);
    op_xor, op_xori:
      res.rd_data = op_a ^ op_b;
    op_srl, op_srli:
      res.rd_data = op_a >> op_b[4:0];
    op_sra, op_srai:
      res.rd_data = word_t'($signed(op_a) >>> op_b[4:0]);
    op_or, op_ori:
      res.rd_data = op_a | op_b;
    op_and, op_andi:
      res.rd_data = op_a & op_b;
    op_jal:
      begin
      res.rd_data = seq_pc;
      taken = 1'b1;
      end
    op_jalr:
      begin
      res.rd_data = seq_pc;
      taken = 1'b1;
      target = (op_a + exec.imm) & ~word_t'(1);
      end
    op_beq:
      taken = (op_a == op_b);
    op_bne:
      taken = (op_a != op_b);
    op_blt:
      taken = ($signed(op_a) < $signed(op_b));
    op_bge:
      taken = ($signed(op_a) >= $signed(op_b));
    op_bltu:
      taken = (op_a < op_b);
    op_bgeu:
      taken = (op_a >= op_b);
    default:
      res.rd_data = '0;
  endcase

  res.valid = exec.valid;
  res.pc = exec.pc;
  res.pc_next = taken ? target : seq_pc;
  res.rd_wr = !is_branch(exec.op);
  res.rd = exec.rd;
  res.br = is_branch(exec.op) || is_jump(exec.op);
  res.br_taken = taken;
  // Every instruction carries a prediction, so any op can miss
  miss = (res.pc_next != exec.pred_pc_next);
  res.br_miss = miss;
  end

always_ff @(posedge clk)
  begin
  wb <= res;
  redirect.valid <= exec.valid && miss;
  redirect.pc <= res.pc_next;
  if (rst)
    begin
    wb.valid <= 1'b0;
    redirect.valid <= 1'b0;
    end
  end

endmodule

/* design/exu_writeback.sv */
`timescale 1ns/10ps

module exu_writeback (
  input  logic              clk,
  input  logic              rst,
  input  exu_pkg::retire_t  wb,
  input  isa_pkg::reg_idx_t rs1,
  input  isa_pkg::reg_idx_t rs2,
  output isa_pkg::word_t    rs1_data,
  output isa_pkg::word_t    rs2_data,
  output exu_pkg::retire_t  retire,
  output logic              release_vld,
  output isa_pkg::reg_idx_t release_rd
);

import isa_pkg::*;
import exu_pkg::*;

word_t   regs [nregs];
retire_t wb_fix;
logic    wr_en;

always_comb
  begin
  wb_fix = wb;
  wb_fix.rd_wr = wb.rd_wr && (wb.rd != '0);   // x0 stays zero
  end

assign wr_en = wb.valid && wb_fix.rd_wr;

// Two combinational read ports for dispatch
assign rs1_data = regs[rs1];
assign rs2_data = regs[rs2];

always_ff @(posedge clk)
  begin
  if (wr_en)
    regs[wb.rd] <= wb.rd_data;
  if (rst)
    for (int i = 0; i < nregs; i++)
      regs[i] <= '0;
  end

always_ff @(posedge clk)
  begin
  retire <= wb_fix;
  release_vld <= wr_en;           // Frees the scoreboard bit
  release_rd <= wb.rd;
  if (rst)
    begin
    retire.valid <= 1'b0;
    release_vld <= 1'b0;
    end
  end

endmodule

/* design/exu_top.sv */
`timescale 1ns/10ps

module exu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  output logic             ack,
  input  exu_pkg::issue_t  issue,
  output exu_pkg::retire_t retire
);

import isa_pkg::*;
import exu_pkg::*;

exec_t     exec;
retire_t   wb;
redirect_t redirect;
reg_idx_t  rs1;
reg_idx_t  rs2;
word_t     rs1_data;
word_t     rs2_data;
logic      release_vld;
reg_idx_t  release_rd;

exu_dispatch dispatch0 (
  .clk,
  .rst,
  .req,
  .ack,
  .issue,
  .redirect,
  .release_vld,
  .release_rd,
  .rs1,
  .rs2,
  .rs1_data,
  .rs2_data,
  .exec
);

exu_execute execute0 (
  .clk,
  .rst,
  .exec,
  .wb,
  .redirect
);

exu_writeback writeback0 (
  .clk,
  .rst,
  .wb,
  .rs1,
  .rs2,
  .rs1_data,
  .rs2_data,
  .retire,
  .release_vld,
  .release_rd
);

endmodule

/* tb/exu_properties.sv */
`timescale 1ns/10ps

module exu_properties (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic exec_valid,
  input logic retire_valid
);

int fail_count = 0;

ack_rise_needs_req: assert property (
  @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
else
  begin
  fail_count++;
  $error("ack rose without a pending req");
  end

ack_held_while_req: assert property (
  @(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
else
  begin
  fail_count++;
  $error("ack fell while req was still high");
  end

ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
else
  begin
  fail_count++;
  $error("ack not low after reset");
  end

retire_single_cycle: assert property (
  @(posedge clk) disable iff (rst) retire_valid |=> !retire_valid)
else
  begin
  fail_count++;
  $error("retire.valid wider than one cycle");
  end

// Accepted instruction retires two sampled cycles after the ack rise
retire_after_accept: assert property (
  @(posedge clk) disable iff (rst) $rose(ack) && exec_valid |-> ##2 retire_valid)
else
  begin
  fail_count++;
  $error("retire.valid missing after accepted instruction");
  end

discard_no_retire: assert property (
  @(posedge clk) disable iff (rst) $rose(ack) && !exec_valid |-> ##2 !retire_valid)
else
  begin
  fail_count++;
  $error("Discarded instruction produced a retire record");
  end

endmodule

bind exu_top exu_properties props0 (
  .clk(clk),
  .rst(rst),
  .req(req),
  .ack(ack),
  .exec_valid(exec.valid),
  .retire_valid(retire.valid)
);

/* tb/exu_tb.sv */
`timescale 1ns/10ps

module exu_tb;

import isa_pkg::*;
import exu_pkg::*;

localparam int wait_limit = 100;

logic    clk;
logic    rst;
logic    req;
logic    ack;
issue_t  issue;
retire_t retire;

logic [31:0] lfsr;
word_t       model_regs [nregs];
word_t       cur_pc;
retire_t     expected [$];
int          errors;
int          checks;
int          tests;

exu_top dut0 (
  .clk,
  .rst,
  .req,
  .ack,
  .issue,
  .retire
);

always #10 clk = ~clk;

// One LFSR step per bit taken with taps 32 22 2 1
function automatic word_t take_bits(int n);
  word_t v;
  v = '0;
  for (int i = 0; i < n; i++)
    begin
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    v = {v[30:0], lfsr[0]};
    end
  return v;
endfunction

function automatic reg_idx_t rand_reg();
  return reg_idx_t'(take_bits(5));
endfunction

function automatic word_t rand_imm12();
  word_t v;
  v = take_bits(12);
  return {{20{v[11]}}, v[11:0]};
endfunction

function automatic word_t alu_value(op_e op, word_t a, word_t b);
  case (op)
    op_add, op_addi: return a + b;
    op_sub: return a - b;
    op_sll, op_slli: return a << b[4:0];
    op_slt, op_slti: return word_t'($signed(a) < $signed(b));
    op_sltu, op_sltiu: return word_t'(a < b);
    op_xor, op_xori: return a ^ b;
    op_srl, op_srli: return a >> b[4:0];
    op_sra, op_srai: return word_t'($signed(a) >>> b[4:0]);
    op_or, op_ori: return a | b;
    op_and, op_andi: return a & b;
    default: return '0;
  endcase
endfunction

function automatic logic branch_taken(op_e op, word_t a, word_t b);
  case (op)
    op_beq: return a == b;
    op_bne: return a != b;
    op_blt: return $signed(a) < $signed(b);
    op_bge: return $signed(a) >= $signed(b);
    op_bltu: return a < b;
    default: return a >= b;       // bgeu
  endcase
endfunction

// Expected retire record from the register model without the prediction
function automatic retire_t predict(issue_t ins);
  retire_t r;
  word_t   a;
  word_t   b;
  a = model_regs[ins.rs1];
  b = model_regs[ins.rs2];
  r = '0;
  r.valid = 1'b1;
  r.pc = ins.pc;
  r.rd = ins.rd;
  r.rd_wr = (ins.rd != 0);
  r.pc_next = ins.pc + inst_len;
  case (ins.op)
    op_lui:
      r.rd_data = ins.imm;
    op_auipc:
      r.rd_data = ins.pc + ins.imm;
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai:
      r.rd_data = alu_value(ins.op, a, ins.imm);
    op_jal, op_jalr:
      begin
      r.br = 1'b1;
      r.br_taken = 1'b1;
      r.rd_data = ins.pc + inst_len;
      r.pc_next = (ins.op == op_jal) ? ins.pc + ins.imm : (a + ins.imm) & 32'hffff_fffe;
      end
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
      begin
      r.br = 1'b1;
      r.rd_wr = 1'b0;
      r.br_taken = branch_taken(ins.op, a, b);
      if (r.br_taken)
        r.pc_next = ins.pc + ins.imm;
      end
    default:
      r.rd_data = alu_value(ins.op, a, b);
  endcase
  return r;
endfunction

task automatic timed_out(string what);
  $display("Timeout at %0t: %s", $time, what);
  $display("TEST RESULT: FAIL");
  $finish;
endtask

task automatic check_field(string name, word_t exp, word_t act);
  checks++;
  assert (act === exp)
  else
    begin
    $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
    errors++;
    end
endtask

task automatic check_record(retire_t exp);
  check_field("retire.pc", exp.pc, retire.pc);
  check_field("retire.pc_next", exp.pc_next, retire.pc_next);
  check_field("retire.rd_wr", exp.rd_wr, retire.rd_wr);
  check_field("retire.rd", exp.rd, retire.rd);
  check_field("retire.rd_data", exp.rd_data, retire.rd_data);
  check_field("retire.br", exp.br, retire.br);
  check_field("retire.br_taken", exp.br_taken, retire.br_taken);
  check_field("retire.br_miss", exp.br_miss, retire.br_miss);
endtask

// Four-phase transfer of one bundle
task automatic handshake(issue_t ins);
  int t;
  issue = ins;
  req = 1'b1;
  t = 0;
  while (!ack)
    begin
    @(posedge clk);
    #1;
    t++;
    if (t > wait_limit)
      timed_out("ack did not rise after req");
    end
  req = 1'b0;
  t = 0;
  while (ack)
    begin
    @(posedge clk);
    #1;
    t++;
    if (t > wait_limit)
      timed_out("ack did not fall after req dropped");
    end
endtask

task automatic run_op(op_e op_sel, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                      word_t imm, logic miss);
  issue_t  ins;
  retire_t exp;
  ins = '{op: op_sel, rs1: rs1, rs2: rs2, rd: rd, imm: imm, pc: cur_pc,
          pred_pc_next: '0};
  exp = predict(ins);
  ins.pred_pc_next = miss ? exp.pc_next + 32'h40 : exp.pc_next;
  exp.br_miss = miss;
  expected.push_back(exp);
  if (exp.rd_wr)
    model_regs[rd] = exp.rd_data;
  cur_pc = exp.pc_next;
  handshake(ins);
endtask

// Off the corrected path so no record is expected
task automatic run_wrong_path(word_t pc);
  issue_t ins;
  ins = '{op: op_addi, rs1: rand_reg(), rs2: 5'd0, rd: rand_reg(), imm: rand_imm12(),
          pc: pc, pred_pc_next: pc + inst_len};
  handshake(ins);
endtask

task automatic finish_test(string name, int errs_before);
  int t;
  t = 0;
  while (expected.size() != 0)
    begin
    @(posedge clk);
    #1;
    t++;
    if (t > wait_limit)
      timed_out("retire records still missing at end of test");
    end
  tests++;
  $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
endtask

always @(negedge clk)
  begin
  if (!rst && retire.valid)
    begin
    checks++;
    assert (expected.size() != 0)
    else
      begin
      $display("Unexpected retire record at %0t for pc %h", $time, retire.pc);
      errors++;
      end
    if (expected.size() != 0)
      check_record(expected.pop_front());
    end
  end

initial
  begin
  int       base;
  reg_idx_t src;
  clk = 1'b0;
  rst = 1'b1;
  req = 1'b0;
  issue = '0;
  lfsr = 32'hbc57_7246;
  errors = 0;
  checks = 0;
  tests = 0;
  cur_pc = 32'h0000_1000;
  for (int i = 0; i < nregs; i++)
    model_regs[i] = '0;
  repeat (4) @(posedge clk);
  #1;
  rst = 1'b0;

  base = errors;
  for (int r = 1; r < nregs; r++)
    begin
    run_op(op_lui, reg_idx_t'(r), 5'd0, 5'd0, take_bits(20) << 12, 1'b0);
    run_op(op_addi, reg_idx_t'(r), reg_idx_t'(r), 5'd0, rand_imm12(), 1'b0);
    end
  finish_test("register seeding", base);

  base = errors;
  for (int i = 0; i < 60; i++)
    run_op(op_e'(take_bits(5) % 21), rand_reg(), rand_reg(), rand_reg(), rand_imm12(), 1'b0);
  finish_test("random alu", base);

  base = errors;
  run_op(op_addi, 5'd0, 5'd3, 5'd0, 32'h123, 1'b0);   // Dropped write to x0
  run_op(op_add, 5'd8, 5'd0, 5'd0, '0, 1'b0);
  run_op(op_ori, 5'd9, 5'd0, 5'd0, 32'h5a5, 1'b0);
  finish_test("x0 reads zero", base);

  base = errors;
  for (int i = 0; i < 10; i++)
    begin
    run_op(op_addi, 5'd10, 5'd10, 5'd0, rand_imm12(), 1'b0);
    run_op(op_xor, 5'd11, 5'd10, 5'd11, '0, 1'b0);
    run_op(op_sub, 5'd10, 5'd11, 5'd10, '0, 1'b0);
    end
  run_op(op_addi, 5'd5, 5'd5, 5'd0, rand_imm12(), 1'b0);
  run_op(op_beq, 5'd5, 5'd1, 5'd2, 32'h8, 1'b0);      // Same rd field as the pending write
  run_op(op_add, 5'd6, 5'd5, 5'd5, '0, 1'b0);
  finish_test("dependent chain", base);

  base = errors;
  for (int i = 0; i < 40; i++)
    begin
    src = rand_reg();
    run_op(op_e'(21 + take_bits(3)), rand_reg(), src, take_bits(1) ? src : rand_reg(),
           rand_imm12() & 32'hffff_fffc, 1'b0);
    end
  finish_test("branches and jumps", base);

  base = errors;
  for (int i = 0; i < 6; i++)
    begin
    run_op((i % 2) ? op_addi : op_e'(23 + take_bits(2)), rand_reg(), rand_reg(), rand_reg(),
           32'h10, 1'b1);
    run_wrong_path(cur_pc + 32'h40);
    run_wrong_path(cur_pc + 32'h44);
    run_op(op_addi, rand_reg(), rand_reg(), 5'd0, rand_imm12(), 1'b0);
    end
  finish_test("mispredict recovery", base);

  $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
           tests, checks, errors, dut0.props0.fail_count);
  if (errors == 0 && dut0.props0.fail_count == 0)
    $display("TEST RESULT: PASS");
  else
    $display("TEST RESULT: FAIL");
  $finish;
  end

endmodule

/* exu_top.f */
design/isa_pkg.sv
design/exu_pkg.sv
design/exu_dispatch.sv
design/exu_execute.sv
design/exu_writeback.sv
design/exu_top.sv
tb/exu_properties.sv
tb/exu_tb.sv
